//--- project.f
rtl/dt_results_pkg.sv
rtl/stream_fifo.sv
rtl/result_input_stage.sv
rtl/result_aggregator.sv
rtl/pcie_result_tx.sv
rtl/engine_csr.sv
rtl/dt_results_top.sv
test/dt_results_checker.sv
test/dt_results_tb.sv

//--- test/dt_results_tb.sv
`timescale 1ns/100ps

module dt_results_tb;

	import dt_results_pkg::*;

	localparam int PKT_LINES = 3;  // Lines per PCIe packet
	// 40 cycles per expected line plus 200 for each of the five tests
	localparam int WATCHDOG_CYCLES = (4 + 3 + 6 + 6) * 40 + 5 * 200;

	logic       clk;
	logic       rst_n;
	apb_req_t   apb_req;
	apb_resp_t  apb_resp;
	word_t      local_result;
	logic       local_result_valid;
	logic       local_result_ready;
	net_word_t  net_rx;
	logic       net_rx_ready;
	pcie_word_t pcie_packet_out;
	logic       pcie_grant;

	word_t local_words[$];  // Stimulus for the local port
	line_t net_lines[$];
	line_t exp_local[$];    // Expected local lines or their sums
	line_t exp_net[$];
	logic  lines_done;
	int    err_cnt = 0;
	int    tests_run = 0;
	int    tests_failed = 0;

	dt_results_top #(
		.FIFO_DEPTH(4)
	) dt_results_top_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.apb_req           (apb_req),
		.apb_resp          (apb_resp),
		.local_result      (local_result),
		.local_result_valid(local_result_valid),
		.local_result_ready(local_result_ready),
		.net_rx            (net_rx),
		.net_rx_ready      (net_rx_ready),
		.pcie_packet_out   (pcie_packet_out),
		.pcie_grant        (pcie_grant)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int error_total();
		return err_cnt + dt_results_top_i.dt_results_checker_i.fail_cnt;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// APB bus

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk);
		apb_req.penable <= 1'b1;  // Access phase
		@(posedge clk);
		apb_req <= '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(posedge clk);
		data = apb_resp.prdata;  // Zero wait states
		err  = apb_resp.pslverr;
		apb_req <= '0;
	endtask

	task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] rd;
		logic        err;
		apb_read(addr, rd, err);
		assert (rd === expected) else begin
			$display("Mismatch prdata at offset %h: got %h expected %h", addr, rd, expected);
			err_cnt++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stream drivers and line monitor

	task automatic send_local();
		foreach (local_words[i]) begin
			local_result       <= local_words[i];
			local_result_valid <= 1'b1;
			@(posedge clk);
			while (!local_result_ready) begin
				@(posedge clk);
			end
		end
		local_result_valid <= 1'b0;
	endtask

	task automatic send_net(input int n_drops);
		net_word_t w;
		int        d = 0;
		int        r = 0;
		while (d < n_drops || r < net_lines.size()) begin
			w.valid = 1'b1;
			if (d < n_drops && (r >= net_lines.size() || d <= r)) begin
				w.data     = {$urandom, $urandom, $urandom, $urandom};
				w.metadata = stream_tag_t'($urandom % 3);  // Anything but results
				d++;
			end else begin
				w.data     = net_lines[r];
				w.metadata = RESULTS_STREAM;
				r++;
			end
			net_rx <= w;
			@(posedge clk);
			while (!net_rx_ready) begin
				@(posedge clk);
			end
		end
		net_rx <= '0;
	endtask

	task automatic drive_grant(input logic stall);
		while (!lines_done) begin
			@(posedge clk);
			pcie_grant <= stall ? ($urandom % 3 != 0) : 1'b1;  // Gaps about one in three
		end
		pcie_grant <= 1'b1;
	endtask

	task automatic collect_lines(input int n_lines, input logic [3:0] slot);
		line_t got;
		logic  hit_local;
		logic  hit_net;
		int    k = 0;
		while (k < n_lines) begin
			@(negedge clk);  // Handshake settled mid cycle
			if (pcie_packet_out.valid && pcie_grant) begin
				got       = pcie_packet_out.data;
				hit_local = exp_local.size() > 0 && got == exp_local[0];
				hit_net   = !hit_local && exp_net.size() > 0 && got == exp_net[0];
				assert (hit_local || hit_net) else begin
					$display("Mismatch pcie_packet_out.data: got %h expected %h", got,
						exp_local.size() > 0 ? exp_local[0] : line_t'(0));
					err_cnt++;
				end
				if (hit_local) begin
					void'(exp_local.pop_front());
				end else if (hit_net) begin
					void'(exp_net.pop_front());
				end
				assert (pcie_packet_out.last == (k % PKT_LINES == PKT_LINES - 1)) else begin
					$display("Mismatch pcie_packet_out.last: got %h expected %h",
						pcie_packet_out.last, k % PKT_LINES == PKT_LINES - 1);
					err_cnt++;
				end
				assert (pcie_packet_out.slot == slot) else begin
					$display("Mismatch pcie_packet_out.slot: got %h expected %h",
						pcie_packet_out.slot, slot);
					err_cnt++;
				end
				k++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_total() != errs_before) begin
			tests_failed++;
		end
		$display("Test %s: %s", name, error_total() == errs_before ? "pass" : "fail");
	endtask

	task automatic run_stream_test(input string name, input logic aggreg, input int n_pairs,
		input int n_drops, input logic stall);
		line_t       loc;
		line_t       net;
		line_t       sum;
		logic [31:0] rd;
		logic        err;
		logic [3:0]  slot;
		int          n_out;
		int          errs_before;
		errs_before = error_total();
		local_words.delete();
		net_lines.delete();
		exp_local.delete();
		exp_net.delete();
		for (int k = 0; k < n_pairs; k++) begin
			for (int j = 0; j < LANES; j++) begin
				loc[j] = $urandom;  // Lane 0 is the first result of the group
				net[j] = $urandom;
				sum[j] = loc[j] + net[j];
				local_words.push_back(loc[j]);
			end
			net_lines.push_back(net);
			if (aggreg) begin
				exp_local.push_back(sum);
			end else begin
				exp_local.push_back(loc);
				exp_net.push_back(net);
			end
		end
		n_out = aggreg ? n_pairs : 2 * n_pairs;
		slot  = 4'($urandom);
		apb_write(REG_PACKET, PKT_LINES - 1);
		apb_write(REG_TOTAL, n_out);
		apb_write(REG_SLOT, {28'd0, slot});
		apb_write(REG_CTRL, {30'd0, aggreg, 1'b1});
		repeat (2) @(posedge clk);  // Let the start pulse clear the FIFOs
		lines_done = 1'b0;
		fork
			send_local();
			send_net(n_drops);
			drive_grant(stall);
			begin
				collect_lines(n_out, slot);
				lines_done = 1'b1;
			end
		join
		rd = '0;
		while (!rd[0]) begin
			apb_read(REG_STATUS, rd, err);  // Poll done
		end
		check_reg(REG_LINES_SENT, n_out);
		check_reg(REG_RX_DROPPED, n_drops);
		report_test(name, errs_before);
	endtask

	task automatic apb_access_test();
		logic [31:0] rd;
		logic        err;
		int          errs_before;
		errs_before = error_total();
		apb_write(REG_PACKET, 32'h0000_00A5);
		apb_write(REG_TOTAL, 32'hDEAD_BEEF);
		apb_write(REG_SLOT, 32'h0000_000C);
		apb_write(REG_CTRL, 32'h0000_0002);  // Aggregation on without start
		check_reg(REG_PACKET, 32'h0000_00A5);
		check_reg(REG_TOTAL, 32'hDEAD_BEEF);
		check_reg(REG_SLOT, 32'h0000_000C);
		check_reg(REG_CTRL, 32'h0000_0002);
		apb_read(8'h20, rd, err);
		assert (err) else begin
			$display("Access to unmapped offset 0x20 did not raise pslverr");
			err_cnt++;
		end
		report_test("apb access", errs_before);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(28608));
		rst_n              <= 1'b0;
		apb_req            <= '0;
		local_result       <= '0;
		local_result_valid <= 1'b0;
		net_rx             <= '0;
		pcie_grant         <= 1'b1;
		lines_done         = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		run_stream_test("merge", 1'b0, 2, 3, 1'b0);
		run_stream_test("aggregation", 1'b1, 3, 2, 1'b0);
		run_stream_test("merge back-pressure", 1'b0, 3, 2, 1'b1);
		run_stream_test("aggregation back-pressure", 1'b1, 6, 1, 1'b1);
		apb_access_test();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
		if (error_total() == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- test/dt_results_checker.sv
`timescale 1ns/100ps

module dt_results_checker (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dt_results_pkg::apb_req_t   apb_req,
	input  dt_results_pkg::apb_resp_t  apb_resp,
	input  dt_results_pkg::pcie_word_t pcie_packet_out,
	input  logic                       pcie_grant,
	input  logic                       done,
	input  logic [31:0]                lines_sent,
	input  logic [31:0]                total_lines
);

	int unsigned fail_cnt = 0;  // Assertion failures so far

	//////////////////////////////////////////////////////////////////////
	// PCIe side

	// Line, slot and last held while the slot stalls
	pcie_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		pcie_packet_out.valid && !pcie_grant |=> $stable(pcie_packet_out))
	else begin
		$error("pcie_packet_out changed while valid was high and grant was low");
		fail_cnt++;
	end

	// Done only after the final transfer
	done_late_a: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(done) |-> lines_sent == total_lines)
	else begin
		$error("done rose before total_lines lines were sent");
		fail_cnt++;
	end

	//////////////////////////////////////////////////////////////////////
	// APB side

	pready_a: assert property (@(posedge clk) disable iff (!rst_n)
		apb_req.psel && apb_req.penable |-> apb_resp.pready)
	else begin
		$error("pready was low in an APB access phase");
		fail_cnt++;
	end

endmodule

bind dt_results_top dt_results_checker dt_results_checker_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.apb_req        (apb_req),
	.apb_resp       (apb_resp),
	.pcie_packet_out(pcie_packet_out),
	.pcie_grant     (pcie_grant),
	.done           (done),
	.lines_sent     (lines_sent),
	.total_lines    (run_cfg.total_lines)
);

//--- rtl/dt_results_top.sv
`timescale 1ns/100ps

module dt_results_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  dt_results_pkg::apb_req_t   apb_req,
	output dt_results_pkg::apb_resp_t  apb_resp,
	input  dt_results_pkg::word_t      local_result,
	input  logic                       local_result_valid,
	output logic                       local_result_ready,
	input  dt_results_pkg::net_word_t  net_rx,
	output logic                       net_rx_ready,
	output dt_results_pkg::pcie_word_t pcie_packet_out,
	input  logic                       pcie_grant
);

	import dt_results_pkg::*;

	run_cfg_t    run_cfg;
	logic        start;
	line_t       local_line;     // Packed local results
	logic        local_line_valid;
	logic        local_line_ready;
	line_t       net_line;       // Network result lines
	logic        net_line_valid;
	logic        net_line_ready;
	line_t       out_line;       // Merged or summed lines
	logic        out_line_valid;
	logic        out_line_ready;
	logic        done;
	logic [31:0] lines_sent;
	logic [31:0] run_cycles;
	logic [31:0] rx_dropped;

	//////////////////////////////////////////////////////////////////////
	// Result path

	result_input_stage #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) result_input_stage_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.start             (start),
		.local_result      (local_result),
		.local_result_valid(local_result_valid),
		.local_result_ready(local_result_ready),
		.net_rx            (net_rx),
		.net_rx_ready      (net_rx_ready),
		.local_line        (local_line),
		.local_line_valid  (local_line_valid),
		.local_line_ready  (local_line_ready),
		.net_line          (net_line),
		.net_line_valid    (net_line_valid),
		.net_line_ready    (net_line_ready),
		.rx_dropped        (rx_dropped)
	);

	result_aggregator result_aggregator_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.aggreg_enable   (run_cfg.aggreg_enable),
		.local_line      (local_line),
		.local_line_valid(local_line_valid),
		.local_line_ready(local_line_ready),
		.net_line        (net_line),
		.net_line_valid  (net_line_valid),
		.net_line_ready  (net_line_ready),
		.out_line        (out_line),
		.out_line_valid  (out_line_valid),
		.out_line_ready  (out_line_ready)
	);

	pcie_result_tx pcie_result_tx_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.start          (start),
		.pcie_slot      (run_cfg.pcie_slot),
		.packet_lines_m1(run_cfg.packet_lines_m1),
		.total_lines    (run_cfg.total_lines),
		.in_line        (out_line),
		.in_valid       (out_line_valid),
		.in_ready       (out_line_ready),
		.pcie_packet_out(pcie_packet_out),
		.pcie_grant     (pcie_grant),
		.done           (done),
		.lines_sent     (lines_sent),
		.run_cycles     (run_cycles)
	);

	//////////////////////////////////////////////////////////////////////
	// Configuration and status

	engine_csr engine_csr_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req   (apb_req),
		.apb_resp  (apb_resp),
		.run_cfg   (run_cfg),
		.start     (start),
		.done      (done),
		.lines_sent(lines_sent),
		.run_cycles(run_cycles),
		.rx_dropped(rx_dropped)
	);

endmodule

//--- rtl/engine_csr.sv
`timescale 1ns/100ps

module engine_csr (
	input  logic                      clk,
	input  logic                      rst_n,
	input  dt_results_pkg::apb_req_t  apb_req,
	output dt_results_pkg::apb_resp_t apb_resp,
	output dt_results_pkg::run_cfg_t  run_cfg,
	output logic                      start,
	input  logic                      done,
	input  logic [31:0]               lines_sent,
	input  logic [31:0]               run_cycles,
	input  logic [31:0]               rx_dropped
);

	import dt_results_pkg::*;

	logic        access;   // APB access phase
	logic        wr_en;
	logic        mapped;   // Offset inside the register map
	logic [31:0] rd_data;

	assign access = apb_req.psel && apb_req.penable;
	assign wr_en  = access && apb_req.pwrite;

	//////////////////////////////////////////////////////////////////////
	// Read side

	always_comb begin
		mapped  = 1'b1;
		rd_data = '0;
		case (apb_req.paddr)
			REG_CTRL:       rd_data = {30'd0, run_cfg.aggreg_enable, 1'b0};  // Start reads 0
			REG_PACKET:     rd_data = {24'd0, run_cfg.packet_lines_m1};
			REG_TOTAL:      rd_data = run_cfg.total_lines;
			REG_SLOT:       rd_data = {28'd0, run_cfg.pcie_slot};
			REG_STATUS:     rd_data = {31'd0, done};
			REG_LINES_SENT: rd_data = lines_sent;
			REG_RUN_CYCLES: rd_data = run_cycles;
			REG_RX_DROPPED: rd_data = rx_dropped;
			default:        mapped = 1'b0;
		endcase
	end

	// Zero wait states
	assign apb_resp = '{prdata: rd_data, pready: 1'b1, pslverr: access && !mapped};

	//////////////////////////////////////////////////////////////////////
	// Write side

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_cfg <= '0;
			start   <= 1'b0;
		end else begin
			// One cycle pulse after the CTRL write
			start <= wr_en && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
			if (wr_en) begin
				case (apb_req.paddr)
					REG_CTRL: begin
						run_cfg.aggreg_enable <= apb_req.pwdata[1];
					end
					REG_PACKET: begin
						run_cfg.packet_lines_m1 <= apb_req.pwdata[7:0];
					end
					REG_TOTAL: begin
						run_cfg.total_lines <= apb_req.pwdata;
					end
					REG_SLOT: begin
						run_cfg.pcie_slot <= apb_req.pwdata[3:0];
					end
					default: begin
						run_cfg <= run_cfg;  // Status and unmapped offsets are read only
					end
				endcase
			end
		end
	end

endmodule

//--- rtl/pcie_result_tx.sv
`timescale 1ns/100ps

module pcie_result_tx (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  logic [3:0]                 pcie_slot,
	input  logic [7:0]                 packet_lines_m1,
	input  logic [31:0]                total_lines,
	input  dt_results_pkg::line_t      in_line,
	input  logic                       in_valid,
	output logic                       in_ready,
	output dt_results_pkg::pcie_word_t pcie_packet_out,
	input  logic                       pcie_grant,
	output logic                       done,
	output logic [31:0]                lines_sent,
	output logic [31:0]                run_cycles
);

	logic [127:0] line_q;
	logic         valid_q;
	logic [7:0]   pkt_cnt;    // Lines already sent in this packet
	logic         pkt_last;
	logic         running_q;  // Between start and done
	logic         take;
	logic         send;

	assign in_ready = !valid_q || pcie_grant;  // Slot frees as the line leaves
	assign take     = in_valid && in_ready;
	assign send     = valid_q && pcie_grant;
	assign pkt_last = pkt_cnt == packet_lines_m1;

	assign pcie_packet_out = '{data: line_q, slot: pcie_slot, valid: valid_q, last: pkt_last};

	always_ff @(posedge clk) begin
		if (take) begin
			line_q <= in_line;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;  // Held while grant is low
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Framing and run status

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			pkt_cnt    <= '0;
			lines_sent <= '0;
			done       <= 1'b0;
			run_cycles <= '0;
			running_q  <= start;  // Only a start opens a run
		end else begin
			if (send) begin
				pkt_cnt    <= pkt_last ? 8'd0 : pkt_cnt + 8'd1;
				lines_sent <= lines_sent + 32'd1;
				if (lines_sent + 32'd1 == total_lines) begin
					done <= 1'b1;  // Sticky until next start
				end
			end
			if (done) begin
				running_q <= 1'b0;
			end
			if (running_q && !done) begin
				run_cycles <= run_cycles + 32'd1;
			end
		end
	end

endmodule

//--- rtl/result_aggregator.sv
`timescale 1ns/100ps

module result_aggregator (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  aggreg_enable,
	input  dt_results_pkg::line_t local_line,
	input  logic                  local_line_valid,
	output logic                  local_line_ready,
	input  dt_results_pkg::line_t net_line,
	input  logic                  net_line_valid,
	output logic                  net_line_ready,
	output dt_results_pkg::line_t out_line,
	output logic                  out_line_valid,
	input  logic                  out_line_ready
);

	import dt_results_pkg::*;

	line_t sum_line;
	line_t out_q;
	logic  out_valid_q;
	logic  load_ok;       // Output register free this cycle
	logic  sel_net;       // Merge choice when not aggregating
	logic  last_net_q;    // Last grant went to the network side
	logic  take_local;
	logic  take_net;

	// Lane-wise sum with 32-bit wrap per lane
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			sum_line[i] = local_line[i] + net_line[i];
		end
	end

	assign load_ok = !out_valid_q || out_line_ready;
	assign sel_net = net_line_valid && (!local_line_valid || !last_net_q);  // Round robin

	always_comb begin
		if (aggreg_enable) begin
			local_line_ready = load_ok && net_line_valid;  // Pairs move together
			net_line_ready   = load_ok && local_line_valid;
		end else begin
			local_line_ready = load_ok && !sel_net;
			net_line_ready   = load_ok && sel_net;
		end
	end

	assign take_local = local_line_valid && local_line_ready;
	assign take_net   = net_line_valid && net_line_ready;

	// Payload register
	always_ff @(posedge clk) begin
		if (aggreg_enable && take_local && take_net) begin
			out_q <= sum_line;
		end else if (take_net) begin
			out_q <= net_line;
		end else if (take_local) begin
			out_q <= local_line;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_q <= 1'b0;
			last_net_q  <= 1'b0;
		end else begin
			if (load_ok) begin
				out_valid_q <= take_local || take_net;  // Refill as old line leaves
			end
			if (!aggreg_enable && (take_local || take_net)) begin
				last_net_q <= take_net;
			end
		end
	end

	assign out_line       = out_q;
	assign out_line_valid = out_valid_q;

endmodule

//--- rtl/result_input_stage.sv
`timescale 1ns/100ps

module result_input_stage #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  dt_results_pkg::word_t    local_result,
	input  logic                     local_result_valid,
	output logic                     local_result_ready,
	input  dt_results_pkg::net_word_t net_rx,
	output logic                     net_rx_ready,
	output dt_results_pkg::line_t    local_line,
	output logic                     local_line_valid,
	input  logic                     local_line_ready,
	output dt_results_pkg::line_t    net_line,
	output logic                     net_line_valid,
	input  logic                     net_line_ready,
	output logic [31:0]              rx_dropped
);

	import dt_results_pkg::*;

	localparam int LANE_W = $clog2(LANES);

	word_t             word_data;
	logic              word_valid;
	logic              word_pop;
	logic [LANE_W-1:0] lane_cnt;      // Next lane to fill
	logic              lane_last;
	line_t             pack_q;        // Shift register of partial line
	line_t             packed_next;
	line_t             line_q;        // Completed line on offer
	logic              line_valid_q;
	logic              is_result;
	logic              net_fifo_ready;
	logic              net_drop;

	//////////////////////////////////////////////////////////////////////
	// Local results into lines

	stream_fifo #(
		.payload_t (word_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) word_fifo_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (start),
		.in_data  (local_result),
		.in_valid (local_result_valid),
		.in_ready (local_result_ready),
		.out_data (word_data),
		.out_valid(word_valid),
		.out_ready(word_pop)
	);

	assign lane_last   = lane_cnt == LANE_W'(LANES - 1);
	assign packed_next = {word_data, pack_q[LANES-1:1]};  // Newest word enters at the top lane
	// Last word of a group waits for room in the output register
	assign word_pop    = word_valid && (!lane_last || !line_valid_q || local_line_ready);

	always_ff @(posedge clk) begin
		if (word_pop) begin
			pack_q <= packed_next;
		end
		if (word_pop && lane_last) begin
			line_q <= packed_next;  // First word of group now in lane 0
		end
	end

	assign local_line       = line_q;
	assign local_line_valid = line_valid_q;

	//////////////////////////////////////////////////////////////////////
	// Network words filtered down to results

	assign is_result    = net_rx.metadata == RESULTS_STREAM;
	assign net_drop     = net_rx.valid && !is_result;            // Weights, indexes, data
	assign net_rx_ready = is_result ? net_fifo_ready : 1'b1;     // Drops never stall

	stream_fifo #(
		.payload_t (line_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) net_fifo_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (start),
		.in_data  (net_rx.data),
		.in_valid (net_rx.valid && is_result),
		.in_ready (net_fifo_ready),
		.out_data (net_line),
		.out_valid(net_line_valid),
		.out_ready(net_line_ready)
	);

	always_ff @(posedge clk) begin
		if (!rst_n || start) begin
			lane_cnt     <= '0;
			line_valid_q <= 1'b0;
			rx_dropped   <= '0;
		end else begin
			if (word_pop) begin
				lane_cnt <= lane_cnt + 1'b1;  // Wraps after the fourth word
			end
			if (word_pop && lane_last) begin
				line_valid_q <= 1'b1;
			end else if (local_line_ready) begin
				line_valid_q <= 1'b0;
			end
			if (net_drop) begin
				rx_dropped <= rx_dropped + 32'd1;
			end
		end
	end

endmodule

//--- rtl/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  FIFO_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     clear,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	payload_t         mem [FIFO_DEPTH];  // Circular buffer
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;             // Fill level
	logic             push;
	logic             pop;

	assign in_ready  = count != CNT_W'(FIFO_DEPTH);  // Not full
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];                  // Head of queue
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at a power-of-two depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle or push with pop
			endcase
		end
	end

endmodule

//--- rtl/dt_results_pkg.sv
package dt_results_pkg;

	// Line geometry
	localparam int LANES  = 4;
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;  // One tree result
	typedef word_t [LANES-1:0] line_t;  // Lane 0 in the low bits

	// Tags carried on the user network
	typedef enum logic [1:0] {
		DATA_STREAM        = 2'd0,
		TREE_WEIGHT_STREAM = 2'd1,
		TREE_FINDEX_STREAM = 2'd2,
		RESULTS_STREAM     = 2'd3
	} stream_tag_t;

	typedef struct packed {
		line_t       data;
		stream_tag_t metadata;
		logic        valid;
	} net_word_t;

	typedef struct packed {
		line_t       data;
		logic [3:0]  slot;
		logic        valid;
		logic        last;   // Final line of a packet
	} pcie_word_t;

	typedef struct packed {
		logic        aggreg_enable;
		logic [7:0]  packet_lines_m1;  // Lines per packet minus one
		logic [31:0] total_lines;
		logic [3:0]  pcie_slot;
	} run_cfg_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_resp_t;

	// Register map
	localparam logic [7:0] REG_CTRL       = 8'h00;  // Bit 0 start, bit 1 aggregation
	localparam logic [7:0] REG_PACKET     = 8'h04;
	localparam logic [7:0] REG_TOTAL      = 8'h08;
	localparam logic [7:0] REG_SLOT       = 8'h0C;
	localparam logic [7:0] REG_STATUS     = 8'h10;  // Bit 0 done
	localparam logic [7:0] REG_LINES_SENT = 8'h14;
	localparam logic [7:0] REG_RUN_CYCLES = 8'h18;
	localparam logic [7:0] REG_RX_DROPPED = 8'h1C;

endpackage
